// ==== m1_mmu.sv ====
//======================================================================
// Memory management unit
// Fetches and in-window data reads go to the prefetch buffer,
// writes and out-of-window reads go to the Wishbone master port
//======================================================================
`timescale 1ns/1ns
`include "m1_settings.svh"

module m1_mmu
  import m1_pkg::*;
(
  input  logic         sys_clock_i,  // System clock
  input  logic         arst_n_i,     // Async reset, active low
  input  logic         imem_read_i,  // Fetch request
  input  logic [31:0]  imem_addr_i,  // Fetch byte address
  output logic         imem_done_o,  // Fetch done
  output logic [31:0]  imem_data_o,  // Fetched word
  input  m1_dmem_req_t dmem_req_i,   // Data request
  output logic         dmem_done_o,  // Data done
  output logic [31:0]  dmem_data_o,  // Data read word
  output m1_wb_req_t   wb_req_o,     // Wishbone master request
  input  m1_wb_rsp_t   wb_rsp_i      // Wishbone response
);

  // Window is the buffer size in bytes, 10 address bits for 256 words
  localparam int WIN_BITS = $clog2(`M1_BUF_WORDS) + 2;

  logic        in_window;   // Address inside the buffer window
  logic        win_read;    // Data read served by the buffer
  logic        bus_access;  // Data access routed to Wishbone
  logic [31:0] buf_i_data;  // Buffer fetch port
  logic [31:0] buf_d_data;  // Buffer data port
  logic        bus_open_q;  // Bus cycle open, ack still pending

  // Routing decided once, everything below follows it
  assign in_window  = (dmem_req_i.addr[31:WIN_BITS] == '0);
  assign win_read   = dmem_req_i.read && !dmem_req_i.write && in_window;
  assign bus_access = (dmem_req_i.read || dmem_req_i.write) && !win_read;

  m1_prefetch_buffer u_prefetch_buffer (
    .sys_clock_i (sys_clock_i),
    .i_addr_i    (imem_addr_i[WIN_BITS-1:2]),      // Word index
    .i_data_o    (buf_i_data),
    .d_addr_i    (dmem_req_i.addr[WIN_BITS-1:2]),  // Word index
    .d_data_o    (buf_d_data)
  );

  // Fetches never wait
  assign imem_done_o = imem_read_i;
  assign imem_data_o = buf_i_data;

  // Wishbone request held as long as the processor holds its level
  assign wb_req_o.cyc = bus_access;
  assign wb_req_o.stb = bus_access;
  assign wb_req_o.we  = bus_access && dmem_req_i.write;  // Writes only
  assign wb_req_o.adr = dmem_req_i.addr;
  assign wb_req_o.dat = dmem_req_i.data;
  assign wb_req_o.sel = dmem_req_i.sel;

  // Done and data from whichever side served the access
  assign dmem_done_o = win_read || (bus_access && wb_rsp_i.ack);
  assign dmem_data_o = win_read ? buf_d_data : wb_rsp_i.dat;

  // Marks an edge where the bus cycle was open and not yet acked
  always_ff @(posedge sys_clock_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      bus_open_q <= 1'b0;
    end else begin
      bus_open_q <= bus_access && !wb_rsp_i.ack;  // Drops after the ack edge
    end
  end

  // Processor must hold the whole request until it sees done
  a_req_stable : assert property (
    @(posedge sys_clock_i) disable iff (!arst_n_i)
    bus_open_q |-> $stable(dmem_req_i)
  ) else $error("data request changed before Wishbone ack");

  a_no_rd_wr : assert property (
    @(posedge sys_clock_i) disable iff (!arst_n_i)
    !(dmem_req_i.read && dmem_req_i.write)
  ) else $error("data read and write high together");

endmodule

// ==== m1_mmu_initial.svh ====
//======================================================================
// Prefetch buffer image, body of an initial block
// Word i gets the image tag on top and its own byte address below
//======================================================================

// Expects the buffer array to be named mem
for (int i = 0; i < `M1_BUF_WORDS; i++) begin
  mem[i].word = {`M1_IMAGE_TAG, 16'(i * 4)};  // Tag plus byte address
end

// ==== m1_pkg.sv ====
//======================================================================
// Shared types of the memory subsystem
// Data port request, Wishbone request and response, word/byte union
//======================================================================
package m1_pkg;

  // Processor data port request, held stable until done
  typedef struct packed {
    logic        read;   // Read level
    logic        write;  // Write level
    logic [31:0] addr;   // Byte address
    logic [31:0] data;   // Write data
    logic [3:0]  sel;    // Byte lanes
  } m1_dmem_req_t;

  // Wishbone master outputs
  typedef struct packed {
    logic        cyc;    // Bus cycle open
    logic        stb;    // Strobe
    logic        we;     // Write enable
    logic [31:0] adr;    // Byte address
    logic [31:0] dat;    // Write data
    logic [3:0]  sel;    // Byte select
  } m1_wb_req_t;

  // Wishbone slave response
  typedef struct packed {
    logic        ack;    // One-cycle acknowledge
    logic [31:0] dat;    // Read data
  } m1_wb_rsp_t;

  // One word seen whole or as four bytes
  typedef union packed {
    logic [31:0]     word;   // Whole word
    logic [3:0][7:0] bytes;  // bytes[0] is bits 7:0
  } m1_word_u;

endpackage

// ==== m1_prefetch_buffer.sv ====
//======================================================================
// Read-only prefetch buffer with two asynchronous read ports
// Instruction port and data port, image loaded at time zero
//======================================================================
`timescale 1ns/1ns
`include "m1_settings.svh"

module m1_prefetch_buffer
  import m1_pkg::*;
(
  input  logic        sys_clock_i,  // System clock, assertion only
  input  logic [7:0]  i_addr_i,     // Instruction word index
  output logic [31:0] i_data_o,     // Instruction word
  input  logic [7:0]  d_addr_i,     // Data word index
  output logic [31:0] d_data_o      // Data word
);

  // Fixed image, no write port
  m1_word_u mem [`M1_BUF_WORDS];

  initial begin
`include "m1_mmu_initial.svh"
  end

  // Both ports answer in the same cycle
  assign i_data_o = mem[i_addr_i].word;  // Fetch path
  assign d_data_o = mem[d_addr_i].word;  // In-window data reads

  // An X here means the image body left a word unloaded
  // or the MMU fed an undriven index into the data port
  a_d_data_known : assert property (
    @(posedge sys_clock_i) !$isunknown(d_data_o)
  ) else $error("prefetch buffer data port returned X");

endmodule

// ==== m1_settings.svh ====
//======================================================================
// Memory subsystem build constants
// Prefetch buffer depth and image tag, RAM depth, bus wait states
//======================================================================
`ifndef M1_SETTINGS_SVH
`define M1_SETTINGS_SVH

// Prefetch buffer depth in 32-bit words
// Window size in bytes is four times this value
`define M1_BUF_WORDS 256

// Upper half of every prefetch buffer word
`define M1_IMAGE_TAG 16'hC0DE

// Wishbone RAM depth in 32-bit words, address wraps modulo this
`define M1_RAM_WORDS 256

// Rising edges with stb high before the RAM acks
// Zero gives an ack on the first edge
`define M1_WB_WAIT_STATES 2

`endif

// ==== m1_top.sv ====
//======================================================================
// Memory subsystem top level
// MMU and Wishbone RAM, bus kept internal
//======================================================================
`timescale 1ns/1ns

module m1_top
  import m1_pkg::*;
(
  input  logic         sys_clock_i,  // System clock
  input  logic         arst_n_i,     // Async reset, active low
  input  logic         imem_read_i,  // Fetch request
  input  logic [31:0]  imem_addr_i,  // Fetch byte address
  output logic         imem_done_o,  // Fetch done
  output logic [31:0]  imem_data_o,  // Fetched word
  input  m1_dmem_req_t dmem_req_i,   // Data request
  output logic         dmem_done_o,  // Data done
  output logic [31:0]  dmem_data_o   // Data read word
);

  m1_wb_req_t wb_req;  // MMU to RAM
  m1_wb_rsp_t wb_rsp;  // RAM to MMU

  m1_mmu u_mmu (
    .sys_clock_i (sys_clock_i),
    .arst_n_i    (arst_n_i),
    .imem_read_i (imem_read_i),
    .imem_addr_i (imem_addr_i),
    .imem_done_o (imem_done_o),
    .imem_data_o (imem_data_o),
    .dmem_req_i  (dmem_req_i),
    .dmem_done_o (dmem_done_o),
    .dmem_data_o (dmem_data_o),
    .wb_req_o    (wb_req),
    .wb_rsp_i    (wb_rsp)
  );

  m1_wb_ram u_wb_ram (
    .sys_clock_i (sys_clock_i),
    .arst_n_i    (arst_n_i),
    .wb_req_i    (wb_req),
    .wb_rsp_o    (wb_rsp)
  );

endmodule

// ==== m1_wb_ram.sv ====
//======================================================================
// Wishbone slave RAM
// Configurable wait states, one-cycle ack, byte-select writes
//======================================================================
`timescale 1ns/1ns
`include "m1_settings.svh"

module m1_wb_ram
  import m1_pkg::*;
(
  input  logic       sys_clock_i,  // System clock
  input  logic       arst_n_i,     // Async reset, active low
  input  m1_wb_req_t wb_req_i,     // Request from the MMU
  output m1_wb_rsp_t wb_rsp_o      // Ack and read data
);

  localparam int AW     = $clog2(`M1_RAM_WORDS);  // Word index width
  localparam int WAIT   = `M1_WB_WAIT_STATES;
  localparam int CNT_W  = (WAIT > 0) ? $clog2(WAIT + 1) : 1;

  logic [31:0]    mem [`M1_RAM_WORDS];  // Storage, not cleared by reset
  logic [AW-1:0]  idx;                  // Word index, wraps
  logic           req_act;              // Strobe seen, not yet served
  logic           ack_set;              // This edge registers ack
  logic [CNT_W-1:0] wait_cnt_q;         // Wait edges counted
  logic           busy_q;               // Acked, waiting for stb low
  logic           ack_q;                // Registered ack
  logic [31:0]    rd_data_q;            // Registered read word
  m1_word_u       old_word;             // Stored word, byte view
  m1_word_u       wr_word;              // Bus write data, byte view
  m1_word_u       merged;               // Word after lane merge

  assign idx     = wb_req_i.adr[AW+1:2];
  assign req_act = wb_req_i.cyc && wb_req_i.stb && !busy_q;
  assign ack_set = req_act && (wait_cnt_q == CNT_W'(WAIT));

  // Only selected lanes take the new byte
  always_comb begin
    old_word.word = mem[idx];
    wr_word.word  = wb_req_i.dat;
    merged        = old_word;
    for (int b = 0; b < 4; b++) begin
      if (wb_req_i.sel[b]) begin
        merged.bytes[b] = wr_word.bytes[b];
      end
    end
  end

  // Wait counter, ack pulse and busy flag
  always_ff @(posedge sys_clock_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wait_cnt_q <= '0;
      busy_q     <= 1'b0;
      ack_q      <= 1'b0;
    end else begin
      ack_q <= ack_set;                    // High for one cycle only
      if (ack_set) begin
        wait_cnt_q <= '0;
        busy_q     <= 1'b1;                // Block a second ack
      end else if (req_act) begin
        wait_cnt_q <= wait_cnt_q + 1'b1;   // Count a wait edge
      end else begin
        wait_cnt_q <= '0;
      end
      if (!wb_req_i.stb) begin
        busy_q <= 1'b0;                    // Strobe fell, ready again
      end
    end
  end

  // Storage access on the edge that registers ack
  always_ff @(posedge sys_clock_i) begin
    if (ack_set) begin
      if (wb_req_i.we) begin
        mem[idx] <= merged.word;
      end
      rd_data_q <= mem[idx];               // Old word, only used on reads
    end
  end

  assign wb_rsp_o.ack = ack_q;
  assign wb_rsp_o.dat = rd_data_q;

  // Ack must only answer a live strobe from the master
  a_ack_with_stb : assert property (
    @(posedge sys_clock_i) disable iff (!arst_n_i)
    wb_rsp_o.ack |-> wb_req_i.stb
  ) else $error("Wishbone ack while stb low");

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# Build the memory subsystem testbench with Verilator, run it, check the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_m1_top -f verilog.f \
  && ./obj_dir/Vtb_m1_top | tee sim.log \
  && grep -qx "Done: no errors" sim.log \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }

// ==== tb_m1_checker.sv ====
//======================================================================
// Testbench checker for the memory subsystem
// RAM model, image rule, value and latency checks, test counts
//======================================================================
`timescale 1ns/1ns
`include "m1_settings.svh"

module tb_m1_checker
  import m1_pkg::*;
(
  input  logic         sys_clock_i,  // Testbench clock
  input  logic         arst_n_i,     // DUT reset
  input  logic         imem_read_i,  // Fetch level as driven
  input  logic [31:0]  imem_addr_i,  // Fetch address as driven
  input  logic         imem_done_i,  // DUT fetch done
  input  logic [31:0]  imem_data_i,  // DUT fetched word
  input  m1_dmem_req_t dmem_req_i,   // Data request as driven
  input  logic         dmem_done_i,  // DUT data done
  input  logic [31:0]  dmem_data_i,  // DUT data word
  output int           err_cnt_o     // Errors so far
);

  m1_word_u ram_model [`M1_RAM_WORDS];  // Expected RAM words, wraps
  int test_cnt = 0;                     // Tests finished
  int fail_cnt = 0;                     // Tests with any error
  int err_cnt  = 0;                     // Single errors

  assign err_cnt_o = err_cnt;

  // Tag on top, the word's own byte address below
  function automatic logic [31:0] image_word(input logic [31:0] addr);
    int idx;
    idx = int'((addr >> 2) % `M1_BUF_WORDS);
    return {`M1_IMAGE_TAG, 16'(idx * 4)};
  endfunction

  task automatic compare_value(input string sig, input logic [31:0] want,
                               input logic [31:0] got, inout logic ok);
    if (got !== want) begin
      $display("** Error at %0t ns: %s expected %h, got %h", $time, sig, want, got);
      err_cnt++;
      ok = 1'b0;
    end
  endtask

  task automatic finish_test(input string what, input logic ok);
    if (!ok) begin
      fail_cnt++;
    end
    $display("Test %0d %s: %s", test_cnt, what, ok ? "ok" : "FAILED");
  endtask

  // Out of reset, a port with no request behind it never reports done
  always @(posedge sys_clock_i) begin
    logic ok;
    ok = 1'b1;
    if (arst_n_i && !imem_read_i) begin
      compare_value("imem_done_o", 32'd0, 32'(imem_done_i), ok);
    end
    if (arst_n_i && !dmem_req_i.read && !dmem_req_i.write) begin
      compare_value("dmem_done_o", 32'd0, 32'(dmem_done_i), ok);
    end
  end

  // No request pending, so neither port may report done
  task automatic check_idle();
    logic ok;
    ok = 1'b1;
    test_cnt++;
    compare_value("imem_done_o", 32'd0, 32'(imem_done_i), ok);
    compare_value("dmem_done_o", 32'd0, 32'(dmem_done_i), ok);
    finish_test("idle after reset", ok);
  endtask

  // Called while the request is still held and done is stable
  task automatic check_access(input logic [31:0] exp, input logic timed_out,
                              input int cycles);
    m1_word_u    merged;   // Model word after the write
    m1_word_u    wr_word;  // Write data, byte view
    logic [31:0] want;
    logic [31:0] addr;
    int          idx;
    logic        ok;
    string       what;
    ok   = 1'b1;
    addr = imem_read_i ? imem_addr_i : dmem_req_i.addr;
    idx  = int'((addr >> 2) % `M1_RAM_WORDS);  // RAM wraps on word index
    what = imem_read_i ? "fetch" : (dmem_req_i.write ? "write" : "read");
    test_cnt++;
    if (timed_out) begin
      $display("Timeout at %0t ns: %s at address %h never got done", $time, what, addr);
      err_cnt++;
      ok = 1'b0;
    end else if (!imem_read_i && dmem_req_i.write) begin
      merged       = ram_model[idx];
      wr_word.word = dmem_req_i.data;
      for (int b = 0; b < 4; b++) begin
        if (dmem_req_i.sel[b]) begin
          merged.bytes[b] = wr_word.bytes[b];  // Selected lane only
        end
      end
      ram_model[idx] = merged;
    end else begin
      if (imem_read_i || addr < `M1_BUF_WORDS * 4) begin
        want = image_word(addr);  // Buffer answers at once
        compare_value(imem_read_i ? "imem_done_o cycles" : "dmem_done_o cycles",
                      32'd0, 32'(cycles), ok);
      end else begin
        want = ram_model[idx].word;  // Bus read from RAM
      end
      compare_value(imem_read_i ? "imem_data_o" : "dmem_data_o", want,
                    imem_read_i ? imem_data_i : dmem_data_i, ok);
      if (exp !== want) begin
        $display("Table value %h at address %h disagrees with model value %h",
                 exp, addr, want);
        err_cnt++;
        ok = 1'b0;
      end
    end
    finish_test($sformatf("%s %h", what, addr), ok);
  endtask

  task automatic report_counts();
    $display("Tests: %0d, passed: %0d, failed: %0d, errors: %0d",
             test_cnt, test_cnt - fail_cnt, fail_cnt, err_cnt);
  endtask

endmodule

// ==== tb_m1_top.sv ====
//======================================================================
// Testbench top for the memory subsystem
// Clock, reset, DUT and checker, stimulus table and driving loop
//======================================================================
`timescale 1ns/1ns
`include "m1_settings.svh"

module tb_m1_top
  import m1_pkg::*;
();

  localparam int         CLK_PERIOD     = 8;
  localparam int         TIMEOUT_CYCLES = 20;    // Per wait for done
  localparam logic [1:0] K_FETCH        = 2'd0;
  localparam logic [1:0] K_READ         = 2'd1;
  localparam logic [1:0] K_WRITE        = 2'd2;

  // One stimulus row
  typedef struct packed {
    logic [1:0]  kind;  // Fetch, read or write
    logic [31:0] addr;  // Byte address
    logic [31:0] data;  // Write data
    logic [3:0]  sel;   // Byte lanes
    logic [31:0] exp;   // Expected read word
  } row_t;

  logic         sys_clock;
  logic         arst_n;
  logic         imem_read;
  logic [31:0]  imem_addr;
  logic         imem_done;
  logic [31:0]  imem_data;
  m1_dmem_req_t dmem_req;
  logic         dmem_done;
  logic [31:0]  dmem_data;
  int           err_cnt;   // From the checker
  row_t         rows [$];  // Stimulus table

  m1_top m1_top_i (
    .sys_clock_i (sys_clock),
    .arst_n_i    (arst_n),
    .imem_read_i (imem_read),
    .imem_addr_i (imem_addr),
    .imem_done_o (imem_done),
    .imem_data_o (imem_data),
    .dmem_req_i  (dmem_req),
    .dmem_done_o (dmem_done),
    .dmem_data_o (dmem_data)
  );

  tb_m1_checker checker_i (
    .sys_clock_i (sys_clock),
    .arst_n_i    (arst_n),
    .imem_read_i (imem_read),
    .imem_addr_i (imem_addr),
    .imem_done_i (imem_done),
    .imem_data_i (imem_data),
    .dmem_req_i  (dmem_req),
    .dmem_done_i (dmem_done),
    .dmem_data_i (dmem_data),
    .err_cnt_o   (err_cnt)
  );

  initial begin
    sys_clock = 1'b0;
    forever #(CLK_PERIOD / 2) sys_clock = ~sys_clock;
  end

  function automatic logic [31:0] word_addr(input logic [7:0] idx);
    return 32'(idx) << 2;
  endfunction

  // Buffer word by index, tag above the byte address
  function automatic logic [31:0] image_value(input logic [7:0] idx);
    return {`M1_IMAGE_TAG, 16'(idx) << 2};
  endfunction

  task automatic add_row(input logic [1:0] kind, input logic [31:0] addr,
                         input logic [31:0] data, input logic [3:0] sel,
                         input logic [31:0] exp);
    rows.push_back(row_t'{kind, addr, data, sel, exp});
  endtask

  task automatic build_table();
    logic [7:0]  fetch_a;
    logic [7:0]  fetch_b;
    logic [7:0]  read_a;
    logic [7:0]  read_b;
    logic [31:0] word_a;
    logic [31:0] word_b;
    fetch_a = 8'($urandom_range(255));
    fetch_b = 8'($urandom_range(255));
    read_a  = 8'($urandom_range(255));
    read_b  = 8'($urandom_range(255));
    word_a  = $urandom;
    word_b  = $urandom;
    add_row(K_FETCH, word_addr(fetch_a), '0, 4'h0, image_value(fetch_a));
    add_row(K_FETCH, word_addr(fetch_b), '0, 4'h0, image_value(fetch_b));
    add_row(K_READ,  word_addr(read_a),  '0, 4'h0, image_value(read_a));
    add_row(K_READ,  word_addr(read_b),  '0, 4'h0, image_value(read_b));
    add_row(K_WRITE, 32'h1000_0104, word_a, 4'hF, '0);  // Full word, off window
    add_row(K_READ,  32'h1000_0104, '0, 4'h0, word_a);
    add_row(K_WRITE, 32'h0000_0800, 32'h1122_3344, 4'hF, '0);
    add_row(K_WRITE, 32'h0000_0800, 32'hAABB_CCDD, 4'b0001, '0);
    add_row(K_READ,  32'h0000_0800, '0, 4'h0, 32'h1122_33DD);
    add_row(K_WRITE, 32'h0000_0800, 32'hAABB_CCDD, 4'b0100, '0);
    add_row(K_READ,  32'h0000_0800, '0, 4'h0, 32'h11BB_33DD);
    add_row(K_WRITE, 32'h0000_0800, 32'h5566_7788, 4'b1010, '0);
    add_row(K_READ,  32'h0000_0800, '0, 4'h0, 32'h55BB_77DD);
    add_row(K_WRITE, 32'h0000_0040, word_b, 4'hF, '0);  // In window, lands in RAM
    add_row(K_READ,  32'h0000_0040, '0, 4'h0, image_value(8'h10));  // Buffer unchanged
    add_row(K_READ,  32'h0000_0440, '0, 4'h0, word_b);  // Alias one window up
  endtask

  task automatic clear_request();
    imem_read = 1'b0;
    imem_addr = '0;
    dmem_req  = '0;
  endtask

  task automatic drive_row(input row_t r);
    if (r.kind == K_FETCH) begin
      imem_read = 1'b1;
      imem_addr = r.addr;
    end else begin
      dmem_req.read  = (r.kind == K_READ);
      dmem_req.write = (r.kind == K_WRITE);
      dmem_req.addr  = r.addr;
      dmem_req.data  = r.data;
      dmem_req.sel   = r.sel;
    end
  endtask

  // Samples a quarter period after the falling edge, away from both edges
  task automatic wait_done(input logic fetch, output logic timed_out, output int cycles);
    cycles = 0;
    #(CLK_PERIOD / 4);
    while (!(fetch ? imem_done : dmem_done) && cycles < TIMEOUT_CYCLES) begin
      @(negedge sys_clock);
      #(CLK_PERIOD / 4);
      cycles++;
    end
    timed_out = !(fetch ? imem_done : dmem_done);
  endtask

  initial begin
    logic timed_out;
    int   cycles;
    arst_n = 1'b0;
    clear_request();
    void'($urandom(6));
    build_table();
    repeat (4) @(posedge sys_clock);
    @(negedge sys_clock);
    arst_n = 1'b1;
    @(negedge sys_clock);
    #(CLK_PERIOD / 4);
    checker_i.check_idle();
    foreach (rows[i]) begin
      @(negedge sys_clock);
      drive_row(rows[i]);
      wait_done(rows[i].kind == K_FETCH, timed_out, cycles);
      checker_i.check_access(rows[i].exp, timed_out, cycles);
      @(negedge sys_clock);  // Held across the edge after ack
      clear_request();
    end
    @(negedge sys_clock);
    checker_i.report_counts();
    if (err_cnt == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// ==== verilog.f ====
+incdir+.
m1_pkg.sv
m1_prefetch_buffer.sv
m1_mmu.sv
m1_wb_ram.sv
m1_top.sv
tb_m1_checker.sv
tb_m1_top.sv
